/* source/udp_rx_config.svh */
`ifndef UDP_RX_CONFIG_SVH
`define UDP_RX_CONFIG_SVH

// **************************************************
// board identity
// **************************************************
`define BOARD_MAC     48'ha0_b1_c2_d3_e1_e1  // unicast address of this port
`define BOARD_IP      32'hc0_a8_01_0b        // 192.168.1.11

// **************************************************
// protocol constants
// **************************************************
`define ETH_TYPE_IPV4 16'h0800               // ipv4 ethertype
`define UDP_HEAD_LEN  16'd8                  // fixed udp header size

`endif

/* source/udp_rx_pkg.sv */
package udp_rx_pkg;

    // **************************************************
    // widths with a meaning
    // **************************************************
    typedef logic [7:0]  byte_t;       // one gmii byte
    typedef logic [47:0] mac_addr_t;   // ethernet mac address
    typedef logic [31:0] ip_addr_t;    // ipv4 address
    typedef logic [15:0] byte_len_t;   // length fields and byte counts
    typedef logic [4:0]  stage_cnt_t;  // byte index inside one stage
    typedef logic [31:0] rx_word_t;    // packed payload word

    // **************************************************
    // frame state machine
    // **************************************************
    typedef enum logic [6:0] {
        st_idle     = 7'b000_0001,   // wait for first preamble byte
        st_preamble = 7'b000_0010,   // rest of preamble and sfd
        st_eth_head = 7'b000_0100,   // mac header
        st_ip_head  = 7'b000_1000,   // ipv4 header incl options
        st_udp_head = 7'b001_0000,   // udp header
        st_rx_data  = 7'b010_0000,   // payload
        st_rx_end   = 7'b100_0000    // wait for line idle
    } rx_state_t;

    // **************************************************
    // grouped signals
    // **************************************************
    // parser results seen by the state machine
    typedef struct packed {
        logic       pre_ok;    // byte is 0x55
        logic       sfd_ok;    // byte is 0xd5
        logic       eth_ok;    // mac and ethertype match
        logic       ip_ok;     // destination ip matches
        logic [5:0] ip_last;   // index of last ip header byte
    } hdr_flags_t;

    // end of packet report
    typedef struct packed {
        logic      rec_pkt_done;  // one cycle after last payload byte
        byte_len_t rec_byte_num;  // payload bytes of last packet
    } rx_status_t;

endpackage

/* source/rx_frame_fsm.sv */
module rx_frame_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   gmii_rx_dv,
    input  udp_rx_pkg::stage_cnt_t cnt,
    input  logic                   data_last,
    input  udp_rx_pkg::hdr_flags_t flags,
    output udp_rx_pkg::rx_state_t  state,
    output logic                   stage_clr
);
    import udp_rx_pkg::*;

    rx_state_t next_state;
    logic      ip_len_bad;   // header length outside what the counter covers

    // ip header must reach past the address and fit the 5 bit index
    assign ip_len_bad = flags.ip_last[5] || (flags.ip_last < 6'd19);

    // **************************************************
    // state register
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // **************************************************
    // next state
    // **************************************************
    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (gmii_rx_dv && flags.pre_ok) begin
                    next_state = st_preamble;   // first 0x55 seen
                end
            end
            st_preamble: begin
                if (gmii_rx_dv) begin
                    if (cnt == 5'd6) begin
                        if (flags.sfd_ok) begin
                            next_state = st_eth_head;
                        end else begin
                            next_state = st_rx_end;   // bad delimiter
                        end
                    end else if (!flags.pre_ok) begin
                        next_state = st_rx_end;
                    end
                end
            end
            st_eth_head: begin
                if (gmii_rx_dv && (cnt == 5'd13)) begin
                    if (flags.eth_ok) begin
                        next_state = st_ip_head;
                    end else begin
                        next_state = st_rx_end;   // not for us or not ipv4
                    end
                end
            end
            st_ip_head: begin
                if (gmii_rx_dv) begin
                    if (cnt == 5'd19) begin
                        if (!flags.ip_ok || ip_len_bad) begin
                            next_state = st_rx_end;
                        end else if ({1'b0, cnt} == flags.ip_last) begin
                            next_state = st_udp_head;   // plain 20 byte header
                        end
                    end else if ((cnt > 5'd19) && ({1'b0, cnt} == flags.ip_last)) begin
                        next_state = st_udp_head;   // options done
                    end
                end
            end
            st_udp_head: begin
                if (gmii_rx_dv && (cnt == 5'd7)) begin
                    next_state = st_rx_data;
                end
            end
            st_rx_data: begin
                if (data_last) begin
                    next_state = st_rx_end;
                end
            end
            st_rx_end: begin
                if (!gmii_rx_dv) begin
                    next_state = st_idle;   // line went idle
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // any change of stage restarts the byte index
    assign stage_clr = (next_state != state);

endmodule

/* source/rx_byte_counter.sv */
module rx_byte_counter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   gmii_rx_dv,
    input  udp_rx_pkg::rx_state_t  state,
    input  logic                   stage_clr,
    input  udp_rx_pkg::byte_len_t  data_len,
    output udp_rx_pkg::stage_cnt_t cnt,
    output logic                   data_last
);
    import udp_rx_pkg::*;

    byte_len_t pay_cnt;    // payload bytes taken so far
    logic      in_header;  // states indexed by cnt

    assign in_header = (state == st_preamble) || (state == st_eth_head) ||
                       (state == st_ip_head)  || (state == st_udp_head);

    // **************************************************
    // byte index within a stage
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (stage_clr) begin
            cnt <= '0;
        end else if (gmii_rx_dv && in_header) begin
            cnt <= cnt + 5'd1;   // gaps just hold the index
        end
    end

    // **************************************************
    // payload byte counter
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pay_cnt <= '0;
        end else if (state != st_rx_data) begin
            pay_cnt <= '0;
        end else if (gmii_rx_dv) begin
            pay_cnt <= pay_cnt + 16'd1;
        end
    end

    // final payload byte is on the bus now
    assign data_last = (state == st_rx_data) && gmii_rx_dv &&
                       (pay_cnt == (data_len - 16'd1));

endmodule

/* source/rx_header_parser.sv */
`include "udp_rx_config.svh"

module rx_header_parser (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   gmii_rx_dv,
    input  udp_rx_pkg::byte_t      gmii_rxd,
    input  udp_rx_pkg::rx_state_t  state,
    input  udp_rx_pkg::stage_cnt_t cnt,
    output udp_rx_pkg::hdr_flags_t flags,
    output udp_rx_pkg::byte_len_t  data_len
);
    import udp_rx_pkg::*;

    mac_addr_t   des_mac;      // destination mac, shifted in
    byte_t       eth_type_hi;  // upper ethertype byte
    logic [23:0] des_ip_hi;    // first three bytes of destination ip
    byte_t       udp_len_hi;   // upper udp length byte
    logic [3:0]  ihl;          // ip header length in words

    logic        mac_ok;
    logic [15:0] eth_type;     // ethertype with current byte
    ip_addr_t    cur_ip;       // destination ip with current byte
    byte_len_t   udp_len;      // udp length with current byte

    // **************************************************
    // field capture
    // **************************************************
    always_ff @(posedge clk) begin
        if (gmii_rx_dv) begin
            case (state)
                st_eth_head: begin
                    if (cnt < 5'd6) begin
                        des_mac <= {des_mac[39:0], gmii_rxd};
                    end
                    if (cnt == 5'd12) begin
                        eth_type_hi <= gmii_rxd;
                    end
                end
                st_ip_head: begin
                    if ((cnt >= 5'd16) && (cnt <= 5'd18)) begin
                        des_ip_hi <= {des_ip_hi[15:0], gmii_rxd};
                    end
                end
                st_udp_head: begin
                    if (cnt == 5'd4) begin
                        udp_len_hi <= gmii_rxd;
                    end
                end
                default: ;
            endcase
        end
    end

    // header length and payload length steer the counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ihl      <= '0;
            data_len <= '0;
        end else if (gmii_rx_dv) begin
            if ((state == st_ip_head) && (cnt == 5'd0)) begin
                ihl <= gmii_rxd[3:0];   // low nibble of version byte
            end
            if ((state == st_udp_head) && (cnt == 5'd5)) begin
                data_len <= udp_len - `UDP_HEAD_LEN;
            end
        end
    end

    // **************************************************
    // compares on the completing byte
    // **************************************************
    assign eth_type = {eth_type_hi, gmii_rxd};
    assign cur_ip   = {des_ip_hi, gmii_rxd};
    assign udp_len  = {udp_len_hi, gmii_rxd};
    assign mac_ok   = (des_mac == `BOARD_MAC) || (des_mac == {48{1'b1}});

    assign flags.pre_ok  = (gmii_rxd == 8'h55);
    assign flags.sfd_ok  = (gmii_rxd == 8'hd5);
    assign flags.eth_ok  = mac_ok && (eth_type == `ETH_TYPE_IPV4);
    assign flags.ip_ok   = (cur_ip == `BOARD_IP);
    assign flags.ip_last = {ihl, 2'b00} - 6'd1;   // 4 x ihl bytes

endmodule

/* source/rx_word_packer.sv */
module rx_word_packer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   gmii_rx_dv,
    input  udp_rx_pkg::byte_t      gmii_rxd,
    input  udp_rx_pkg::rx_state_t  state,
    input  logic                   data_last,
    input  udp_rx_pkg::byte_len_t  data_len,
    output logic                   rec_en,
    output udp_rx_pkg::rx_word_t   rec_data,
    output udp_rx_pkg::rx_status_t status
);
    import udp_rx_pkg::*;

    logic [1:0] lane;   // byte position in the current word
    logic       take;   // payload byte on the bus

    assign take = (state == st_rx_data) && gmii_rx_dv;

    // **************************************************
    // byte lanes and strobes
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane                <= '0;
            rec_en              <= 1'b0;
            rec_data            <= '0;
            status.rec_pkt_done <= 1'b0;
            status.rec_byte_num <= '0;
        end else begin
            rec_en              <= 1'b0;
            status.rec_pkt_done <= 1'b0;
            if (state != st_rx_data) begin
                lane <= '0;
            end else if (take) begin
                lane <= lane + 2'd1;
                case (lane)
                    2'd0: rec_data[31:24] <= gmii_rxd;   // first byte on top
                    2'd1: rec_data[23:16] <= gmii_rxd;
                    2'd2: rec_data[15:8]  <= gmii_rxd;
                    default: begin
                        rec_data[7:0] <= gmii_rxd;
                        rec_en        <= 1'b1;   // word complete
                    end
                endcase
                if (data_last) begin
                    lane                <= '0;
                    status.rec_pkt_done <= 1'b1;
                    status.rec_byte_num <= data_len;   // held until next done
                end
            end
        end
    end

endmodule

/* source/udp_rx.sv */
module udp_rx (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   gmii_rx_dv,
    input  udp_rx_pkg::byte_t      gmii_rxd,
    output logic                   rec_en,
    output udp_rx_pkg::rx_word_t   rec_data,
    output udp_rx_pkg::rx_status_t status
);
    import udp_rx_pkg::*;

    rx_state_t  state;       // registered frame stage
    logic       stage_clr;
    stage_cnt_t cnt;
    logic       data_last;
    hdr_flags_t flags;
    byte_len_t  data_len;    // payload bytes from udp header

    // **************************************************
    // control
    // **************************************************
    rx_frame_fsm fsm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .gmii_rx_dv (gmii_rx_dv),
        .cnt        (cnt),
        .data_last  (data_last),
        .flags      (flags),
        .state      (state),
        .stage_clr  (stage_clr)
    );

    rx_byte_counter cnt_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .gmii_rx_dv (gmii_rx_dv),
        .state      (state),
        .stage_clr  (stage_clr),
        .data_len   (data_len),
        .cnt        (cnt),
        .data_last  (data_last)
    );

    // **************************************************
    // data path
    // **************************************************
    rx_header_parser hdr_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rxd   (gmii_rxd),
        .state      (state),
        .cnt        (cnt),
        .flags      (flags),
        .data_len   (data_len)
    );

    rx_word_packer pack_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rxd   (gmii_rxd),
        .state      (state),
        .data_last  (data_last),
        .data_len   (data_len),
        .rec_en     (rec_en),
        .rec_data   (rec_data),
        .status     (status)
    );

endmodule

/* bench/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

    // reset held low for a fixed number of rising edges
    initial begin
        rst_n <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* bench/udp_rx_tb.sv */
`include "udp_rx_config.svh"

module udp_rx_tb;
    import udp_rx_pkg::*;

    localparam int          CLK_PERIOD = 10;
    localparam int          RST_CYCLES = 16;
    localparam int          NUM_FRAMES = 12;
    localparam int          GAP_CYCLES = 12;
    localparam logic [31:0] SEED       = 32'd94843;
    localparam logic [31:0] LFSR_TAPS  = 32'hd000_0001;  // x^32 + x^31 + x^29 + x + 1

    typedef struct packed {
        logic [1:0] pre_err;   // 1 bad preamble byte, 2 bad sfd
        mac_addr_t  dst_mac;
        byte_len_t  eth_type;
        ip_addr_t   dst_ip;
        logic [3:0] ihl;
        byte_len_t  pay_len;
        byte_len_t  pay_gap;   // idle cycles before this payload byte
    } frame_t;

    logic       clk;
    logic       rst_n;
    logic       gmii_rx_dv;
    byte_t      gmii_rxd;
    logic       rec_en;
    rx_word_t   rec_data;
    rx_status_t status;

    logic [31:0] lfsr;
    byte_t       frame_q[$];     // whole frame on the wire
    byte_t       pay_q[$];       // payload part only
    rx_word_t    exp_words[$];
    byte_len_t   exp_lens[$];
    byte_len_t   last_len;       // count the dut must hold

    tb_clock_gen #(
        .PERIOD     (CLK_PERIOD),
        .RST_CYCLES (RST_CYCLES)
    ) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    udp_rx dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rxd   (gmii_rxd),
        .rec_en     (rec_en),
        .rec_data   (rec_data),
        .status     (status)
    );

    // **************************************************
    // stimulus helpers
    // **************************************************
    // galois lfsr stepped once per bit taken
    function automatic byte_t rand_byte();
        byte_t b;
        for (int i = 0; i < 8; i++) begin
            b    = {b[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return b;
    endfunction

    function automatic frame_t frame_at(input int idx);
        frame_t f;
        f.pre_err  = 2'd0;
        f.dst_mac  = `BOARD_MAC;
        f.eth_type = `ETH_TYPE_IPV4;
        f.dst_ip   = `BOARD_IP;
        f.ihl      = 4'd5;
        f.pay_len  = 16'd64;
        f.pay_gap  = 16'd0;
        case (idx)
            1: f.dst_mac = 48'hffff_ffff_ffff;         // broadcast
            2: f.dst_mac = 48'h02_11_22_33_44_55;      // other station
            3: f.pay_len = 16'd20;
            4: f.eth_type = 16'h86dd;                  // ipv6
            5: begin
                f.pay_len = 16'd13;
                f.pay_gap = 16'd5;                     // dv drops mid payload
            end
            6: f.dst_ip = `BOARD_IP ^ 32'd1;
            7: begin
                f.dst_mac = 48'hffff_ffff_ffff;
                f.pay_len = 16'd3;                     // no full word
            end
            8: f.pre_err = 2'd1;
            10: f.pre_err = 2'd2;
            11: begin
                f.ihl     = 4'd6;                      // one option word
                f.pay_len = 16'd27;
            end
            default: ;
        endcase
        return f;
    endfunction

    function automatic void push_field(input logic [47:0] value, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            frame_q.push_back(value[i*8 +: 8]);       // network order
        end
    endfunction

    function automatic void build_frame(input frame_t f);
        byte_len_t ip_len;
        ip_len = {10'd0, f.ihl, 2'b00} + 16'd8 + f.pay_len;
        frame_q.delete();
        pay_q.delete();
        push_field(48'h55_55_55_55_55_55, 6);
        push_field(48'h55_d5, 2);
        if (f.pre_err == 2'd1) begin
            frame_q[3] = 8'h57;
        end else if (f.pre_err == 2'd2) begin
            frame_q[7] = 8'hd4;
        end
        push_field(f.dst_mac, 6);
        push_field(48'h02_00_00_00_00_01, 6);         // source mac
        push_field(48'(f.eth_type), 2);
        push_field(48'({4'h4, f.ihl, 8'h00, ip_len}), 4);
        push_field(48'h0001_4000, 4);                 // id and dont fragment
        push_field(48'h4011_0000, 4);                 // ttl 64 and protocol udp
        push_field(48'hc0a8_0102, 4);                 // source ip
        push_field(48'(f.dst_ip), 4);
        for (int i = 20; i < 4 * int'(f.ihl); i++) begin
            frame_q.push_back(8'h01);                 // nop options
        end
        push_field(48'h1f90_1f91, 4);                 // ports
        push_field(48'({f.pay_len + 16'd8, 16'h0000}), 4);
        for (int i = 0; i < int'(f.pay_len); i++) begin
            pay_q.push_back(rand_byte());
            frame_q.push_back(pay_q[i]);
        end
    endfunction

    // expected words and count from the frame fields
    function automatic void predict_frame(input frame_t f);
        logic accept;
        accept = (f.pre_err == 2'd0) && (f.eth_type == `ETH_TYPE_IPV4) &&
                 ((f.dst_mac == `BOARD_MAC) || (f.dst_mac == 48'hffff_ffff_ffff)) &&
                 (f.dst_ip == `BOARD_IP);
        if (accept) begin
            for (int i = 0; i + 3 < int'(f.pay_len); i += 4) begin
                exp_words.push_back({pay_q[i], pay_q[i+1], pay_q[i+2], pay_q[i+3]});
            end
            exp_lens.push_back(f.pay_len);
        end
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("** Error @ %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            gmii_rx_dv <= 1'b0;
            gmii_rxd   <= 8'h00;
        end
    endtask

    task automatic run_frame(input int idx);
        frame_t f;
        int     hdr;
        f   = frame_at(idx);
        hdr = 30 + 4 * int'(f.ihl);                   // preamble up to udp header
        build_frame(f);
        predict_frame(f);
        foreach (frame_q[i]) begin
            if ((f.pay_gap != 16'd0) && (i == hdr + int'(f.pay_gap))) begin
                idle_cycles(3);
            end
            @(posedge clk);
            gmii_rx_dv <= 1'b1;
            gmii_rxd   <= frame_q[i];
        end
        idle_cycles(GAP_CYCLES);
        check_equal(exp_words.size(), 0, $sformatf("words missing after frame %0d", idx));
        check_equal(exp_lens.size(), 0, $sformatf("done missing after frame %0d", idx));
    endtask

    // **************************************************
    // monitor and compare
    // **************************************************
    always @(negedge clk) begin
        if (rst_n) begin
            if (rec_en) begin
                check_equal(32'(exp_words.size() != 0), 32'd1, "unexpected word strobe");
                check_equal(rec_data, exp_words.pop_front(), "payload word");
            end
            if (status.rec_pkt_done) begin
                check_equal(32'(exp_lens.size() != 0), 32'd1, "unexpected done strobe");
                last_len = exp_lens.pop_front();
            end
            check_equal(32'(status.rec_byte_num), 32'(last_len), "byte count");
        end
    end

    initial begin
        gmii_rx_dv <= 1'b0;
        gmii_rxd   <= 8'h00;
        lfsr     = SEED;
        last_len = '0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_equal(rec_data, 32'd0, "word after reset");
        check_equal(32'({rec_en, status.rec_pkt_done}), 32'd0, "strobes after reset");
        for (int i = 0; i < NUM_FRAMES; i++) begin
            run_frame(i);
        end
        $display("*** PASSED ***");
        $finish;
    end

    // watchdog sized from the frame table
    initial begin
        int     total;
        frame_t f;
        total = RST_CYCLES + 4;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            f     = frame_at(i);
            total = total + 33 + 4 * int'(f.ihl) + int'(f.pay_len) + GAP_CYCLES;
        end
        #(total * CLK_PERIOD * 2);
        $display("timeout: frames did not complete within %0d clock cycles", total * 2);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

/* compile.f */
+incdir+source
source/udp_rx_pkg.sv
source/rx_frame_fsm.sv
source/rx_byte_counter.sv
source/rx_header_parser.sv
source/rx_word_packer.sv
source/udp_rx.sv
bench/tb_clock_gen.sv
bench/udp_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the udp receive testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module udp_rx_tb -o udp_rx_sim

out=$(./obj_dir/udp_rx_sim 2>&1 || true)
printf '%s\n' "$out"

# result is decided by the pass line alone
printf '%s\n' "$out" | grep -qF '*** PASSED ***'
